/* multi_drive.f */
src/drive_cfg_pkg.sv
src/iec_bus_pkg.sv
src/phase_gen.sv
src/shared_rom.sv
src/rom_slot_arbiter.sv
src/drive_core.sv
src/iec_bus_port.sv
src/multi_drive.sv
test/tb_clock.sv
test/multi_drive_assertions.sv
test/multi_drive_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the multi-drive testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module multi_drive_tb -Mdir obj_dir -o multi_drive_sim \
	-f multi_drive.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/multi_drive_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
	exit 1
fi
exit 0

/* src/drive_cfg_pkg.sv */
// ==========================================================================
// Drive configuration package
// Drive count, program ROM geometry, frame length, the width types
// and the drive sequencer state encoding
// ==========================================================================

package drive_cfg_pkg;

	localparam int NDR       = 4;  // Drive cores on the bus
	localparam int ROM_AW    = 10; // Shared ROM address bits
	localparam int FRAME_LEN = 8;  // Clock cycles per frame

	typedef logic [ROM_AW-1:0]            rom_addr_t;
	typedef logic [7:0]                   rom_byte_t;
	typedef logic [NDR-1:0]               drive_mask_t; // One bit per drive
	typedef logic [$clog2(FRAME_LEN)-1:0] slot_t;       // Position inside a frame

	// HOLD while the drive is kept in reset
	typedef enum logic {
		RUN,
		HOLD
	} drv_state_e;

endpackage

/* src/drive_core.sv */
// ==========================================================================
// Drive core
// Small sequencer: once per frame it takes the fetched program byte,
// drives the serial lines from bits 2..0 and the LED from bit 3, and
// steps its program counter
// ==========================================================================

module drive_core #(
	parameter int DRV_IDX = 0
) (
	input  logic                     clk,
	input  logic                     rst_n_i,
	input  logic                     drv_rst_i,
	input  logic                     ph2_f_i,
	output drive_cfg_pkg::rom_addr_t rom_addr_o,
	input  drive_cfg_pkg::rom_byte_t rom_data_i,
	output iec_bus_pkg::iec_lines_t  lines_o,
	output logic                     led_o
);
	import drive_cfg_pkg::*;
	import iec_bus_pkg::*;

	// Each drive owns one quarter of the ROM
	localparam rom_addr_t BASE = rom_addr_t'(DRV_IDX * 2**(ROM_AW - 2));

	drv_state_e state_q;
	rom_addr_t  pc_q;
	iec_lines_t lines_q;
	logic       led_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i || drv_rst_i) begin
			state_q <= HOLD;
			pc_q    <= BASE;
			lines_q <= '1;   // Lines released
			led_q   <= 1'b0;
		end else begin
			state_q <= RUN;
			// A pulse in the release cycle is skipped, so the next frame refetches BASE
			if (state_q == RUN && ph2_f_i) begin
				lines_q <= iec_lines_t'(rom_data_i[2:0]);
				led_q   <= rom_data_i[3];
				pc_q    <= pc_q + 1'b1; // Wraps at the top of the ROM
			end
		end
	end

	assign rom_addr_o = pc_q;
	assign lines_o    = lines_q;
	assign led_o      = led_q;

endmodule

/* src/iec_bus_pkg.sv */
// ==========================================================================
// Serial bus package
// Bus line bundle (open collector, 1 = released) and the ROM write port
// ==========================================================================

package iec_bus_pkg;

	// Line levels as driven by one drive or seen on the merged bus.
	// A drive in reset or idle leaves all lines at 1.
	typedef struct packed {
		logic data;    // Bit 2 of the program byte
		logic clk;     // Bit 1
		logic atn_ack; // Bit 0
	} iec_lines_t;

	// External ROM load, one byte per cycle with we high
	typedef struct packed {
		logic                     we;
		drive_cfg_pkg::rom_addr_t addr;
		drive_cfg_pkg::rom_byte_t data;
	} rom_wr_t;

endpackage

/* src/iec_bus_port.sv */
// ==========================================================================
// Bus port
// Two-flop synchronizers on the per-drive resets, the open-collector
// merge of the drive lines and blanking of LEDs for drives in reset
// ==========================================================================

module iec_bus_port (
	input  logic                       clk,
	input  logic                       rst_n_i,
	input  drive_cfg_pkg::drive_mask_t drv_rst_i,
	output drive_cfg_pkg::drive_mask_t drv_rst_sync_o,
	input  iec_bus_pkg::iec_lines_t    drv_lines_i [drive_cfg_pkg::NDR],
	input  drive_cfg_pkg::drive_mask_t drv_led_i,
	output iec_bus_pkg::iec_lines_t    bus_o,
	output drive_cfg_pkg::drive_mask_t act_led_o
);
	import drive_cfg_pkg::*;
	import iec_bus_pkg::*;

	drive_mask_t rst_meta_q;
	drive_mask_t rst_sync_q;

	// All drives held until the first synchronized value arrives
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rst_meta_q <= '1;
			rst_sync_q <= '1;
		end else begin
			rst_meta_q <= drv_rst_i;
			rst_sync_q <= rst_meta_q;
		end
	end

	// Wired-AND over the drives out of reset
	always_comb begin
		bus_o = '1;
		for (int i = 0; i < NDR; i++) begin
			if (!rst_sync_q[i])
				bus_o = iec_lines_t'(bus_o & drv_lines_i[i]);
		end
	end

	assign act_led_o      = drv_led_i & ~rst_sync_q;
	assign drv_rst_sync_o = rst_sync_q;

endmodule

/* src/multi_drive.sv */
// ==========================================================================
// Multi-drive subsystem top
// Phase generator, shared ROM, slot arbiter, drive cores and bus port
// ==========================================================================

module multi_drive (
	input  logic                       clk,
	input  logic                       rst_n_i,
	input  logic                       pause_i,
	input  drive_cfg_pkg::drive_mask_t drv_rst_i,
	input  iec_bus_pkg::rom_wr_t       rom_wr_i,
	output iec_bus_pkg::iec_lines_t    bus_o,
	output drive_cfg_pkg::drive_mask_t act_led_o
);
	import drive_cfg_pkg::*;
	import iec_bus_pkg::*;

	slot_t       slot;
	logic        ph2_f;
	rom_addr_t   rom_addr;
	rom_byte_t   rom_data;
	rom_addr_t   drv_addr  [NDR];
	rom_byte_t   drv_data  [NDR];
	iec_lines_t  drv_lines [NDR];
	drive_mask_t drv_led;
	drive_mask_t drv_rst_sync;

	phase_gen i_phase_gen (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.pause_i (pause_i),
		.slot_o  (slot),
		.ph2_f_o (ph2_f)
	);

	shared_rom i_rom (
		.clk       (clk),
		.wr_i      (rom_wr_i),
		.rd_addr_i (rom_addr),
		.rd_data_o (rom_data)
	);

	rom_slot_arbiter i_arbiter (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.slot_i     (slot),
		.drv_addr_i (drv_addr),
		.rom_addr_o (rom_addr),
		.rom_data_i (rom_data),
		.drv_data_o (drv_data)
	);

	for (genvar i = 0; i < NDR; i++) begin : g_drive
		drive_core #(.DRV_IDX(i)) i_drive (
			.clk        (clk),
			.rst_n_i    (rst_n_i),
			.drv_rst_i  (drv_rst_sync[i]),
			.ph2_f_i    (ph2_f),
			.rom_addr_o (drv_addr[i]),
			.rom_data_i (drv_data[i]),
			.lines_o    (drv_lines[i]),
			.led_o      (drv_led[i])
		);
	end

	iec_bus_port i_bus_port (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.drv_rst_i      (drv_rst_i),
		.drv_rst_sync_o (drv_rst_sync),
		.drv_lines_i    (drv_lines),
		.drv_led_i      (drv_led),
		.bus_o          (bus_o),
		.act_led_o      (act_led_o)
	);

endmodule

/* src/phase_gen.sv */
// ==========================================================================
// Phase generator
// Counts the slots of an eight-cycle frame and pulses ph2_f in the last
// slot. Pause freezes the count and suppresses the pulse
// ==========================================================================

module phase_gen (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 pause_i,
	output drive_cfg_pkg::slot_t slot_o,
	output logic                 ph2_f_o
);
	import drive_cfg_pkg::*;

	slot_t slot_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			slot_q <= '0;
		end else if (!pause_i) begin
			slot_q <= (slot_q == slot_t'(FRAME_LEN - 1)) ? '0 : slot_q + 1'b1;
		end
	end

	assign slot_o  = slot_q;
	assign ph2_f_o = (slot_q == slot_t'(FRAME_LEN - 1)) && !pause_i; // End of frame

endmodule

/* src/rom_slot_arbiter.sv */
// ==========================================================================
// ROM slot arbiter
// Slots 0..NDR-1 each issue one read for the drive of that number. The
// drive index travels with the request so the returned byte lands in
// the right register two cycles later
// ==========================================================================

module rom_slot_arbiter (
	input  logic                     clk,
	input  logic                     rst_n_i,
	input  drive_cfg_pkg::slot_t     slot_i,
	input  drive_cfg_pkg::rom_addr_t drv_addr_i [drive_cfg_pkg::NDR],
	output drive_cfg_pkg::rom_addr_t rom_addr_o,
	input  drive_cfg_pkg::rom_byte_t rom_data_i,
	output drive_cfg_pkg::rom_byte_t drv_data_o [drive_cfg_pkg::NDR]
);
	import drive_cfg_pkg::*;

	localparam int IW = $clog2(NDR);

	logic          req_vld;
	logic [IW-1:0] req_idx;
	logic [1:0]    vld_q;      // Address stage, data stage
	logic [IW-1:0] idx_q [2];
	rom_addr_t     addr_q;
	rom_byte_t     data_q [NDR];

	assign req_vld = (slot_i < slot_t'(NDR));
	assign req_idx = slot_i[IW-1:0];

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			vld_q  <= '0;
			addr_q <= '0;
		end else begin
			vld_q <= {vld_q[0], req_vld};
			if (req_vld)
				addr_q <= drv_addr_i[req_idx];
		end
	end

	// Index follows the ROM read latency
	always_ff @(posedge clk) begin
		idx_q[0] <= req_idx;
		idx_q[1] <= idx_q[0];
		if (vld_q[1])
			data_q[idx_q[1]] <= rom_data_i; // Slots 2..5 in a running frame
	end

	assign rom_addr_o = addr_q;
	assign drv_data_o = data_q;

endmodule

/* src/shared_rom.sv */
// ==========================================================================
// Shared program ROM
// Single array with an external write port and one registered read port
// ==========================================================================

module shared_rom (
	input  logic                     clk,
	input  iec_bus_pkg::rom_wr_t     wr_i,
	input  drive_cfg_pkg::rom_addr_t rd_addr_i,
	output drive_cfg_pkg::rom_byte_t rd_data_o
);
	import drive_cfg_pkg::*;

	rom_byte_t mem [2**ROM_AW] = '{default: '0};
	rom_byte_t rd_data_q;

	always_ff @(posedge clk) begin
		if (wr_i.we)
			mem[wr_i.addr] <= wr_i.data;
		rd_data_q <= mem[rd_addr_i]; // Old byte on a same-cycle write
	end

	assign rd_data_o = rd_data_q;

endmodule

/* test/multi_drive_assertions.sv */
// ==========================================================================
// Phase and arbiter assertions
// ph2_f only in the last slot, slot hold and step, and every drive byte
// captured before slot 6
// ==========================================================================

module multi_drive_assertions #(
	parameter bit ARB = 1'b0 // Set when bound to the arbiter
) (
	input logic                 clk,
	input logic                 rst_n_i,
	input logic                 pause_i,
	input logic                 ph2_f_i,
	input drive_cfg_pkg::slot_t slot_i,
	input logic                 cap_i
);
	import drive_cfg_pkg::*;

	a_ph2_last_slot: assert property (@(posedge clk) disable iff (!rst_n_i || ARB)
		ph2_f_i |-> slot_i == slot_t'(FRAME_LEN - 1))
		else $error("ph2_f pulsed outside the last slot");

	a_slot_hold: assert property (@(posedge clk) disable iff (!rst_n_i || ARB)
		pause_i |=> $stable(slot_i))
		else $error("slot moved while paused");

	a_slot_step: assert property (@(posedge clk) disable iff (!rst_n_i || ARB)
		!pause_i |=> slot_i == slot_t'($past(slot_i) + 1'b1))
		else $error("slot did not advance by one");

	// Four requests plus two cycles of read latency
	a_bytes_settled: assert property (@(posedge clk) disable iff (!rst_n_i || !ARB)
		slot_i >= slot_t'(NDR + 2) |-> !cap_i)
		else $error("drive byte captured after the fetch slots");

endmodule

bind phase_gen multi_drive_assertions #(.ARB(1'b0)) i_phase_checks (
	.clk     (clk),
	.rst_n_i (rst_n_i),
	.pause_i (pause_i),
	.ph2_f_i (ph2_f_o),
	.slot_i  (slot_o),
	.cap_i   (1'b0)
);

bind rom_slot_arbiter multi_drive_assertions #(.ARB(1'b1)) i_arb_checks (
	.clk     (clk),
	.rst_n_i (rst_n_i),
	.pause_i (1'b0),
	.ph2_f_i (1'b0),
	.slot_i  (slot_i),
	.cap_i   (vld_q[1])
);

/* test/multi_drive_tb.sv */
// ==========================================================================
// Multi-drive subsystem testbench
// Random stimulus checked every cycle against a model of the frame,
// the ROM fetch slots, the reset synchronizers and the bus merge
// ==========================================================================

module multi_drive_tb;
	import drive_cfg_pkg::*;
	import iec_bus_pkg::*;

	localparam int LOAD_LEN   = 2**ROM_AW + 6 * FRAME_LEN;
	localparam int MERGE_LEN  = 10 * FRAME_LEN;
	localparam int BURST_LEN  = 12 * 21;                  // Reset test and pause test each
	localparam int REWR_LEN   = 16 * 9 + 4 * FRAME_LEN;
	localparam int MAX_CYCLES = 16 + LOAD_LEN + MERGE_LEN + 2 * BURST_LEN + REWR_LEN + 100;

	logic        clk;
	logic        rst_n;
	logic        pause;
	drive_mask_t drv_rst;
	rom_wr_t     rom_wr;
	iec_lines_t  bus;
	drive_mask_t act_led;

	rom_byte_t   m_rom [2**ROM_AW] = '{default: '0};
	rom_addr_t   m_pc [NDR];
	rom_byte_t   m_byte [NDR];
	logic [2:0]  m_lines [NDR]; // data, clk, atn_ack
	drive_mask_t m_led;
	drive_mask_t m_run;
	drive_mask_t m_meta;
	drive_mask_t m_sync;
	slot_t       m_slot;
	logic        f1_vld;        // Address registered
	logic        f2_vld;        // ROM byte returned
	logic [1:0]  f1_idx;
	logic [1:0]  f2_idx;
	rom_addr_t   f1_addr;
	rom_byte_t   f2_data;

	int   cycles   = 0;
	int   checks   = 0;
	int   errors   = 0;
	int   tests    = 0;
	int   failed   = 0;
	logic check_en = 1'b0;

	tb_clock #(.PERIOD(100), .RST_CYCLES(8)) i_clock (
		.clk     (clk),
		.rst_n_o (rst_n)
	);

	multi_drive i_dut (
		.clk       (clk),
		.rst_n_i   (rst_n),
		.pause_i   (pause),
		.drv_rst_i (drv_rst),
		.rom_wr_i  (rom_wr),
		.bus_o     (bus),
		.act_led_o (act_led)
	);

	task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got 0x%h, expected 0x%h (cycle %0d)", name, got, exp, cycles);
		end
	endtask

	// Reference model for one clock edge, computed from pre-edge values
	task automatic step_model();
		logic      ph2;
		logic      req;
		rom_addr_t req_addr;
		ph2      = (m_slot == slot_t'(FRAME_LEN - 1)) && !pause;
		req      = (m_slot < NDR);
		req_addr = m_pc[m_slot[1:0]];
		for (int i = 0; i < NDR; i++) begin
			if (!rst_n || m_sync[i]) begin
				m_run[i]   = 1'b0;
				m_pc[i]    = rom_addr_t'(i * 2**(ROM_AW - 2));
				m_lines[i] = '1;
				m_led[i]   = 1'b0;
			end else begin
				if (m_run[i] && ph2) begin
					m_lines[i] = m_byte[i][2:0];
					m_led[i]   = m_byte[i][3];
					m_pc[i]    = m_pc[i] + 1'b1;
				end
				m_run[i] = 1'b1;
			end
		end
		if (f2_vld)
			m_byte[f2_idx] = f2_data;
		f2_vld  = f1_vld && rst_n;
		f2_idx  = f1_idx;
		f2_data = m_rom[f1_addr]; // Read before this edge's write
		f1_vld  = req && rst_n;
		f1_idx  = m_slot[1:0];
		if (req)
			f1_addr = req_addr;
		if (rom_wr.we)
			m_rom[rom_wr.addr] = rom_wr.data;
		m_sync = rst_n ? m_meta : '1;
		m_meta = rst_n ? drv_rst : '1;
		if (!rst_n)
			m_slot = '0;
		else if (!pause)
			m_slot = slot_t'((m_slot + 1) % FRAME_LEN);
	endtask

	task automatic run_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic end_test(input string name, input int err_start);
		tests++;
		if (errors != err_start)
			failed++;
		$display("Test %0d %s: %s, %0d errors", tests, name,
			(errors == err_start) ? "ok" : "wrong outputs", errors - err_start);
	endtask

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display(">>> FAIL");
			$finish;
		end else begin
			step_model();
		end
	end

	always @(negedge clk) begin
		logic [2:0] exp_bus;
		exp_bus = '1;
		for (int i = 0; i < NDR; i++)
			if (!m_sync[i])
				exp_bus = exp_bus & m_lines[i];
		if (check_en) begin
			check("bus_o", {5'b0, bus}, {5'b0, exp_bus});
			check("act_led_o", {4'b0, act_led}, {4'b0, m_led & ~m_sync});
		end
	end

	initial begin
		int        e0;
		int        d;
		rom_addr_t a;
		void'($urandom(32'h6cde_ceab));
		pause   = 1'b0;
		drv_rst = '1;
		rom_wr  = '0;
		@(posedge rst_n);
		check_en = 1'b1;

		e0 = errors;
		drv_rst <= 4'b1110; // Only drive 0 runs during the load
		for (int i = 0; i < 2**ROM_AW; i++) begin
			@(posedge clk);
			rom_wr <= '{we: 1'b1, addr: rom_addr_t'(i), data: rom_byte_t'($urandom)};
		end
		@(posedge clk);
		rom_wr.we <= 1'b0;
		run_cycles(6 * FRAME_LEN);
		end_test("rom load and fetch", e0);

		e0 = errors;
		drv_rst <= '0;
		run_cycles(MERGE_LEN);
		end_test("wired-and merge", e0);

		e0 = errors;
		for (int k = 0; k < 12; k++) begin
			drv_rst <= drive_mask_t'($urandom);
			run_cycles(3 + $urandom % 18);
		end
		drv_rst <= '0;
		end_test("per-drive reset", e0);

		e0 = errors;
		for (int k = 0; k < 12; k++) begin
			pause <= 1'b1;
			run_cycles(1 + $urandom % 10);
			pause <= 1'b0;
			run_cycles(1 + $urandom % 10);
		end
		end_test("pause bursts", e0);

		e0 = errors;
		for (int k = 0; k < 16; k++) begin
			@(negedge clk);
			d = $urandom % NDR;
			a = m_pc[d] + rom_addr_t'(2); // Two bytes ahead of the drive
			@(posedge clk);
			rom_wr <= '{we: 1'b1, addr: a, data: rom_byte_t'($urandom)};
			@(posedge clk);
			rom_wr.we <= 1'b0;
			run_cycles($urandom % 8);
		end
		run_cycles(4 * FRAME_LEN);
		end_test("rewrite while running", e0);

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests, failed, checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* test/tb_clock.sv */
// ==========================================================================
// Testbench clock and reset
// Free-running clock and an active-low reset held for the first cycles
// ==========================================================================

module tb_clock #(
	parameter int PERIOD     = 100,
	parameter int RST_CYCLES = 8
) (
	output logic clk,
	output logic rst_n_o
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		rst_n_o <= 1'b1; // Released on a rising edge
	end

endmodule
